//--- common/pulse_cfg_if.sv
// Configuration is static while running; events are single-cycle pulses from the playback side
`timescale 1ns/100ps

interface pulse_cfg_if;
    import pulse_pkg::*;

    // Run control from the register block
    logic running;
    logic start_pulse;
    // Mode and output shaping bits
    logic use_2bps;
    logic loop_forever;
    logic idle_level;
    logic invert;
    logic carrier_en;
    // Index {bit, half}, so low0 low1 high0 high1
    logic [3:0][1:0] sym_code;
    logic [pc_w-1:0] start_idx;
    logic [pc_w-1:0] end_idx;
    logic [pc_w-1:0] loop_idx;
    logic [loop_w-1:0] loop_count;
    // Duration per symbol code
    logic [3:0][dur_w-1:0] dur;
    logic [presc_w-1:0] prescaler;
    logic [carrier_w-1:0] carrier_half;
    logic [data_w-1:0] prog_word;
    // Back from the playback side
    logic [prog_idx_w-1:0] word_sel;
    logic symbol_evt;
    logic loop_evt;
    logic end_evt;
    logic [pc_w-1:0] pc;
    logic [loop_w-1:0] loop_cnt;

    modport regs (
        output running, start_pulse, use_2bps, loop_forever, idle_level, invert, carrier_en,
        output sym_code, start_idx, end_idx, loop_idx, loop_count,
        output dur, prescaler, carrier_half, prog_word,
        input  word_sel, symbol_evt, loop_evt, end_evt, pc, loop_cnt
    );

    modport play (
        input  running, start_pulse, use_2bps, loop_forever, idle_level, invert, carrier_en,
        input  sym_code, start_idx, end_idx, loop_idx, loop_count,
        input  dur, prescaler, carrier_half, prog_word,
        output word_sel, symbol_evt, loop_evt, end_evt, pc, loop_cnt
    );

endinterface

//--- common/pulse_pkg.sv
// Register map and field positions assume word-aligned 32-bit accesses and a fixed 8-word program
package pulse_pkg;

    // Bus and datapath widths
    localparam int data_w         = 32;
    localparam int addr_w         = 6;
    localparam int pc_w           = 8;
    localparam int loop_w         = 8;
    localparam int dur_w          = 8;
    localparam int presc_w        = 4;
    localparam int carrier_w      = 12;
    localparam int num_prog_words = 8;
    localparam int prog_idx_w     = 3;
    // Symbol, loop and end interrupts
    localparam int num_irq        = 3;

    // Register offsets, program word n at prog_base_addr + 4n
    localparam logic [addr_w-1:0] reg_ctrl_addr    = 6'h00;
    localparam logic [addr_w-1:0] reg_index_addr   = 6'h04;
    localparam logic [addr_w-1:0] reg_dur_addr     = 6'h08;
    localparam logic [addr_w-1:0] reg_presc_addr   = 6'h0C;
    localparam logic [addr_w-1:0] reg_carrier_addr = 6'h10;
    localparam logic [addr_w-1:0] prog_base_addr   = 6'h20;

    // Control register
    localparam int ctrl_int_pos     = 0;
    localparam int ctrl_start_pos   = 4;
    localparam int ctrl_stop_pos    = 5;
    localparam int ctrl_int_en_pos  = 8;
    localparam int ctrl_forever_pos = 12;
    localparam int ctrl_idle_pos    = 13;
    localparam int ctrl_invert_pos  = 14;
    localparam int ctrl_carrier_pos = 15;
    localparam int ctrl_2bps_pos    = 17;
    // Low bit halves then high bit halves, 2 bits each
    localparam int ctrl_sym_pos     = 18;

    // Index register bytes
    localparam int idx_start_pos = 0;
    localparam int idx_end_pos   = 8;
    localparam int idx_loop_pos  = 16;
    localparam int idx_count_pos = 24;

    localparam int presc_pos   = 28;
    localparam int carrier_pos = 0;

    // Read word layout, status sits at ctrl_int_pos
    localparam int rd_run_pos  = 4;
    localparam int rd_loop_pos = 8;
    localparam int rd_pc_pos   = 16;

    // data_write_n code of a full word write
    localparam logic [1:0] wr_word_code = 2'b10;

    // One program word seen as 2-bit codes or as single bits
    typedef union packed {
        logic [data_w/2-1:0][1:0] sym2;
        logic [data_w-1:0]        bit1;
    } prog_word_u;

endpackage

//--- list.f
common/pulse_pkg.sv
common/pulse_cfg_if.sv
sequencer/pulse_timer.sv
sequencer/pulse_sequencer.sv
verilog/pulse_regs.sv
verilog/carrier_gen.sv
verilog/pulse_tx_top.sv
tests/pulse_tx_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and scan the log for failures
cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module pulse_tx_tb --Mdir "$build_dir" -o pulse_tx_sim -f list.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$build_dir/pulse_tx_sim" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"

if grep -q "Test failures found" "$log_file"; then
    echo "Simulation reported failures"
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi
echo "Simulation finished without failures"
exit 0

//--- sequencer/pulse_sequencer.sv
// Indices must be even in two-bits mode, and an end index that is never reached wraps the program
`timescale 1ns/100ps

module pulse_sequencer (
    input  logic      clk,
    input  logic      rst_n,
    pulse_cfg_if.play cfg,
    output logic      tx_level,
    output logic      tx_valid
);
    import pulse_pkg::*;

    logic              sp_d1;
    logic              sp_d2;
    logic              half;
    logic              eof;
    logic              loop_evt_q;
    logic [pc_w-1:0]   pc;
    logic [loop_w-1:0] loop_cnt;
    prog_word_u        word;
    logic              bit_val;
    logic [1:0]        code;
    logic [dur_w-1:0]  duration;
    logic              done;
    logic              load;
    logic              at_step;
    logic              at_end;
    logic              do_loop;

    // Start pipeline, pulse then fetch then prefetch
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sp_d1 <= 1'b0;
            sp_d2 <= 1'b0;
        end else begin
            sp_d1 <= cfg.start_pulse;
            sp_d2 <= sp_d1;
        end
    end

    assign tx_valid = cfg.running && !cfg.start_pulse && !sp_d1 && !sp_d2;

    // Upper pc bits select the word
    assign cfg.word_sel = pc[pc_w-1 -: prog_idx_w];
    assign word         = cfg.prog_word;

    // Symbol decode of the word at pc
    always_comb begin
        bit_val = word.bit1[pc[pc_w-prog_idx_w-1:0]];
        if (cfg.use_2bps) begin
            code = word.sym2[pc[pc_w-prog_idx_w-1:1]];
        end else begin
            code = cfg.sym_code[{bit_val, half}];
        end
        duration = cfg.dur[code];
    end

    // First load at the end of the prefetch cycle, then on each finished symbol
    assign load    = (sp_d2 && cfg.running) || (done && tx_valid && !eof);
    assign at_step = cfg.use_2bps || half;
    assign at_end  = (pc == cfg.end_idx);
    assign do_loop = cfg.loop_forever || (loop_cnt != '0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc         <= '0;
            half       <= 1'b0;
            eof        <= 1'b0;
            loop_cnt   <= '0;
            loop_evt_q <= 1'b0;
        end else if (!cfg.running) begin
            // Idle, track the configured start point
            pc         <= cfg.start_idx;
            half       <= 1'b0;
            eof        <= 1'b0;
            loop_cnt   <= cfg.loop_count;
            loop_evt_q <= 1'b0;
        end else begin
            loop_evt_q <= 1'b0;
            if (load) begin
                if (!cfg.use_2bps) begin
                    half <= !half;
                end
                if (at_step) begin
                    if (!at_end) begin
                        // Step of 2 in two-bits mode, else 1
                        pc <= pc + {{(pc_w-2){1'b0}}, cfg.use_2bps, !cfg.use_2bps};
                    end else if (do_loop) begin
                        pc         <= cfg.loop_idx;
                        loop_cnt   <= loop_cnt - 1'b1;
                        loop_evt_q <= 1'b1;
                    end else begin
                        // Last symbol is loaded, end when it finishes
                        eof <= 1'b1;
                    end
                end
            end
        end
    end

    // Level of the symbol being played
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tx_level <= 1'b0;
        end else if (load) begin
            tx_level <= code[1];
        end
    end

    pulse_timer i_pulse_timer (
        .clk       (clk),
        .rst_n     (rst_n),
        .load      (load),
        .duration  (duration),
        .prescaler (cfg.prescaler),
        .done      (done)
    );

    assign cfg.symbol_evt = done && tx_valid;
    assign cfg.end_evt    = done && tx_valid && eof;
    assign cfg.loop_evt   = loop_evt_q;
    assign cfg.pc         = pc;
    assign cfg.loop_cnt   = loop_cnt;

    a_pc_even: assert property (@(posedge clk) disable iff (!rst_n)
        (cfg.running && cfg.use_2bps && !cfg.start_pulse) |-> !pc[0])
        else $error("odd program counter in two-bits mode");

endmodule

//--- sequencer/pulse_timer.sv
// Symbol lasts (duration + 1) * (prescaler + 1) cycles after load, idles after done without reload
`timescale 1ns/100ps

module pulse_timer (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          load,
    input  logic [pulse_pkg::dur_w-1:0]   duration,
    input  logic [pulse_pkg::presc_w-1:0] prescaler,
    output logic                          done
);
    import pulse_pkg::*;

    logic               busy;
    logic               tick;
    logic [presc_w-1:0] presc_cnt;
    logic [presc_w-1:0] presc_lim;
    logic [dur_w-1:0]   dur_cnt;
    logic [dur_w-1:0]   dur_lim;

    // Prescaler stage expires at zero
    assign tick = (presc_cnt == '0);
    assign done = busy && tick && (dur_cnt == dur_lim);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            presc_cnt <= '0;
            presc_lim <= '0;
            dur_cnt   <= '0;
            dur_lim   <= '0;
        end else if (load) begin
            // Reload beats a done in the same cycle
            busy      <= 1'b1;
            presc_cnt <= prescaler;
            presc_lim <= prescaler;
            dur_cnt   <= '0;
            dur_lim   <= duration;
        end else if (done) begin
            busy <= 1'b0;
        end else if (busy) begin
            if (tick) begin
                presc_cnt <= presc_lim;
                dur_cnt   <= dur_cnt + 1'b1;
            end else begin
                presc_cnt <= presc_cnt - 1'b1;
            end
        end
    end

    a_dur_bound: assert property (@(posedge clk) disable iff (!rst_n)
        busy |-> (dur_cnt <= dur_lim))
        else $error("duration count ran past its load value");

endmodule

//--- tests/pulse_tx_tb.sv
// Stops at the first mismatch; program words and durations are random from a fixed seed of 4
`timescale 1ns/100ps

module pulse_tx_tb;
    import pulse_pkg::*;

    logic              clk;
    logic              rst_n;
    logic [addr_w-1:0] address;
    logic [data_w-1:0] data_in;
    logic [1:0]        data_write_n;
    logic [1:0]        data_read_n;
    logic [data_w-1:0] data_out;
    logic              data_ready;
    logic              tx_out;
    logic              tx_valid;
    logic              carrier_out;
    logic              user_interrupt;

    // Copy of what the host wrote for the reference model
    logic [data_w-1:0]    ctrl_reg;
    logic [data_w-1:0]    index_reg;
    logic [data_w-1:0]    dur_reg;
    logic [presc_w-1:0]   presc_reg;
    logic [carrier_w-1:0] carrier_reg;
    prog_word_u           prog [num_prog_words];

    // Expected tx_out and carrier_out per cycle from the rise of tx_valid
    logic   exp_q [$];
    logic   exp_car_q [$];
    int     exp_len = 0;
    logic   armed = 1'b0;
    logic   cmp_done = 1'b0;
    int     cmp_idx = 0;
    // Cycle limit that grows with every planned program
    int     budget = 1000;
    int     cycles = 0;
    integer seed = 4;

    pulse_tx_top i_pulse_tx_top (
        .clk            (clk),
        .rst_n          (rst_n),
        .address        (address),
        .data_in        (data_in),
        .data_write_n   (data_write_n),
        .data_read_n    (data_read_n),
        .data_out       (data_out),
        .data_ready     (data_ready),
        .tx_out         (tx_out),
        .tx_valid       (tx_valid),
        .carrier_out    (carrier_out),
        .user_interrupt (user_interrupt)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic stop_on_error(input string msg);
        $display("ERROR at %0t ns: %s", $time, msg);
        $display("Test failures found");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_level(input logic got, input logic exp, input string where);
        if (got !== exp) begin
            stop_on_error($sformatf("tx_out %s is %b, expected %b", where, got, exp));
        end
    endtask

    task automatic check_word(input logic [data_w-1:0] got, input logic [data_w-1:0] exp,
                              input string what);
        if (got !== exp) begin
            stop_on_error($sformatf("%s is %h, expected %h", what, got, exp));
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            stop_on_error($sformatf("%s is %b, expected %b", what, got, exp));
        end
    endtask

    // One full word write that lands at the second rising edge
    task automatic bus_write(input logic [addr_w-1:0] addr, input logic [data_w-1:0] data);
        @(posedge clk);
        address      <= addr;
        data_in      <= data;
        data_write_n <= wr_word_code;
        @(posedge clk);
        data_write_n <= 2'b11;
    endtask

    task automatic fill_program();
        logic [prog_idx_w-1:0] wi;
        wi = '0;
        do begin
            prog[wi] = $random(seed);
            wi = wi + 1'b1;
        end while (wi != '0);
    endtask

    task automatic load_config();
        logic [prog_idx_w-1:0] wi;
        bus_write(reg_index_addr, index_reg);
        bus_write(reg_dur_addr, dur_reg);
        bus_write(reg_presc_addr, {presc_reg, {presc_pos{1'b0}}});
        bus_write(reg_carrier_addr, {{(data_w-carrier_w){1'b0}}, carrier_reg});
        wi = '0;
        do begin
            bus_write(prog_base_addr | {1'b0, wi, 2'b00}, prog[wi]);
            wi = wi + 1'b1;
        end while (wi != '0);
        // Control goes last and holds no start bit
        bus_write(reg_ctrl_addr, ctrl_reg);
    endtask

    // Expands registers and memory into the per-cycle output and returns its length
    function automatic int build_expected();
        logic [pc_w-1:0]       pc;
        logic [loop_w-1:0]     loops;
        logic [3:0][1:0]       codes;
        logic [3:0][dur_w-1:0] durs;
        logic                  two_bit;
        logic                  half;
        logic                  bit_val;
        logic                  playing;
        logic                  car;
        logic                  lvl;
        logic [1:0]            code;
        int                    len;
        int                    k;
        exp_q.delete();
        exp_car_q.delete();
        codes   = ctrl_reg[ctrl_sym_pos +: 8];
        durs    = dur_reg;
        two_bit = ctrl_reg[ctrl_2bps_pos];
        pc      = index_reg[idx_start_pos +: pc_w];
        loops   = index_reg[idx_count_pos +: loop_w];
        half    = 1'b0;
        playing = 1'b1;
        k       = 0;
        while (playing) begin
            // With 32 bits per word pc[7:5] picks the word
            if (two_bit) begin
                code = prog[pc[7:5]].sym2[pc[4:1]];
            end else begin
                bit_val = prog[pc[7:5]].bit1[pc[4:0]];
                code    = codes[{bit_val, half}];
            end
            len = (int'(durs[code]) + 1) * (int'(presc_reg) + 1);
            repeat (len) begin
                // Carrier starts high and flips every half period + 1 cycles
                car = ((k / (int'(carrier_reg) + 1)) % 2) == 0;
                lvl = ctrl_reg[ctrl_carrier_pos] ? (code[1] & car) : code[1];
                exp_q.push_back(lvl ^ ctrl_reg[ctrl_invert_pos]);
                exp_car_q.push_back(car);
                k = k + 1;
            end
            if (two_bit || half) begin
                if (pc != index_reg[idx_end_pos +: pc_w]) begin
                    pc = pc + (two_bit ? 8'd2 : 8'd1);
                end else if (ctrl_reg[ctrl_forever_pos] || loops != '0) begin
                    pc    = index_reg[idx_loop_pos +: pc_w];
                    loops = loops - 8'd1;
                end else begin
                    playing = 1'b0;
                end
            end
            if (!two_bit) begin
                half = !half;
            end
        end
        return k;
    endfunction

    task automatic run_program();
        exp_len = build_expected();
        budget  = budget + exp_len + 50;
        bus_write(reg_ctrl_addr, ctrl_reg | (32'd1 << ctrl_start_pos));
        armed = 1'b1;
        // Start pulse, fetch and prefetch
        repeat (3) begin
            @(negedge clk);
            check_flag(tx_valid, 1'b0, "tx_valid before the first symbol");
        end
        @(negedge clk);
        check_flag(tx_valid, 1'b1, "tx_valid three cycles after the start write");
        wait (cmp_done);
        armed = 1'b0;
        @(negedge clk);
    endtask

    // Compare process samples once per cycle on the falling edge
    always @(negedge clk) begin
        if (!armed) begin
            cmp_idx  = 0;
            cmp_done = 1'b0;
        end else if (!cmp_done && (cmp_idx > 0 || tx_valid)) begin
            if (cmp_idx < exp_len) begin
                check_flag(tx_valid, 1'b1, "tx_valid during the program");
                check_level(tx_out, exp_q[cmp_idx],
                            $sformatf("at program cycle %0d", cmp_idx));
                check_flag(carrier_out, exp_car_q[cmp_idx], "carrier_out");
                cmp_idx = cmp_idx + 1;
            end else begin
                // First cycle after the last symbol
                check_flag(tx_valid, 1'b0, "tx_valid after the last symbol");
                check_flag(data_out[rd_run_pos], 1'b0, "running after the last symbol");
                cmp_done = 1'b1;
            end
        end
    end

    // Watchdog
    initial begin
        forever begin
            @(posedge clk);
            cycles = cycles + 1;
            if (cycles > budget) begin
                stop_on_error($sformatf("watchdog expired after %0d cycles", cycles));
            end
        end
    end

    initial begin
        rst_n        <= 1'b0;
        address      <= '0;
        data_in      <= '0;
        data_write_n <= 2'b11;
        data_read_n  <= 2'b11;
        repeat (16) @(posedge clk);
        rst_n       <= 1'b1;
        data_read_n <= 2'b10;
        @(negedge clk);

        // Reset state
        check_word(data_out, '0, "read word after reset");
        check_flag(tx_valid, 1'b0, "tx_valid after reset");
        check_flag(user_interrupt, 1'b0, "user_interrupt after reset");
        check_flag(carrier_out, 1'b0, "carrier_out after reset");
        check_flag(data_ready, 1'b1, "data_ready");
        check_level(tx_out, 1'b0, "after reset");

        // Two-bits mode across a word boundary
        fill_program();
        dur_reg     = $random(seed) & 32'h0707_0707;
        index_reg   = {8'd0, 8'd0, 8'd40, 8'd24};
        presc_reg   = 4'd2;
        carrier_reg = 12'd5;
        ctrl_reg    = 32'd1 << ctrl_2bps_pos;
        load_config();
        run_program();

        // One-bit mode with codes 01 10 for a low bit and 11 00 for a high bit
        fill_program();
        dur_reg   = $random(seed) & 32'h0303_0303;
        index_reg = {8'd0, 8'd0, 8'd18, 8'd5};
        presc_reg = 4'd1;
        ctrl_reg  = 32'h39 << ctrl_sym_pos;
        load_config();
        run_program();

        // Loop twice back to index 2 with only the loop and end interrupts enabled
        dur_reg   = $random(seed) & 32'h0303_0303;
        index_reg = {8'd2, 8'd2, 8'd6, 8'd0};
        presc_reg = 4'd0;
        ctrl_reg  = (32'd1 << ctrl_2bps_pos) | (32'h6 << ctrl_int_en_pos);
        load_config();
        run_program();
        // Status bits 2..0 and running bit 4
        check_word(data_out & 32'h17, 32'h6, "status after the looping program");
        check_flag(user_interrupt, 1'b1, "user_interrupt after the looping program");
        bus_write(reg_ctrl_addr, ctrl_reg | 32'h6);
        @(negedge clk);
        check_word(data_out & 32'h17, 32'h0, "status after write one to clear");
        check_flag(user_interrupt, 1'b0, "user_interrupt after clear");

        // Carrier gating with the output inverted
        fill_program();
        dur_reg     = ($random(seed) & 32'h0303_0303) | 32'h0404_0404;
        index_reg   = {8'd0, 8'd0, 8'd10, 8'd0};
        presc_reg   = 4'd1;
        carrier_reg = 12'd3;
        ctrl_reg    = (32'd1 << ctrl_2bps_pos) | (32'd1 << ctrl_carrier_pos)
                    | (32'd1 << ctrl_invert_pos);
        load_config();
        @(negedge clk);
        check_level(tx_out, 1'b1, "idle low level inverted");
        run_program();

        // Stop in the middle of a long program with the idle level high
        dur_reg   = 32'h2020_2020;
        index_reg = {8'd0, 8'd0, 8'd30, 8'd0};
        presc_reg = 4'd0;
        ctrl_reg  = (32'd1 << ctrl_2bps_pos) | (32'd1 << ctrl_idle_pos);
        // Low first symbol so the return to the high idle level is visible
        prog[0].sym2[0] = 2'b00;
        load_config();
        budget = budget + 100;
        bus_write(reg_ctrl_addr, ctrl_reg | (32'd1 << ctrl_start_pos));
        repeat (4) @(negedge clk);
        check_flag(tx_valid, 1'b1, "tx_valid before the stop");
        repeat (20) @(negedge clk);
        check_flag(data_out[rd_run_pos], 1'b1, "running before the stop");
        check_level(tx_out, 1'b0, "in the first symbol before the stop");
        bus_write(reg_ctrl_addr, ctrl_reg | (32'd1 << ctrl_stop_pos));
        @(negedge clk);
        check_flag(tx_valid, 1'b0, "tx_valid after the stop");
        check_flag(data_out[rd_run_pos], 1'b0, "running after the stop");
        check_level(tx_out, 1'b1, "after the stop");

        $display("All tests passed!");
        $finish;
    end

endmodule

//--- verilog/carrier_gen.sv
// Carrier runs only while the output is valid and gates high symbols only when enabled
`timescale 1ns/100ps

module carrier_gen (
    input  logic      clk,
    input  logic      rst_n,
    pulse_cfg_if.play cfg,
    input  logic      tx_level,
    input  logic      tx_valid,
    output logic      carrier_out,
    output logic      tx_out
);
    import pulse_pkg::*;

    logic [carrier_w-1:0] half_cnt;
    logic                 phase;
    logic                 shaped;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            half_cnt <= '0;
            phase    <= 1'b1;
        end else if (!tx_valid) begin
            // Armed to restart high on the next valid cycle
            half_cnt <= '0;
            phase    <= 1'b1;
        end else if (half_cnt == cfg.carrier_half) begin
            half_cnt <= '0;
            phase    <= !phase;
        end else begin
            half_cnt <= half_cnt + 1'b1;
        end
    end

    assign carrier_out = tx_valid && phase;

    // Gate, then idle, then invert
    assign shaped = cfg.carrier_en ? (tx_level && carrier_out) : tx_level;
    assign tx_out = (tx_valid ? shaped : cfg.idle_level) ^ cfg.invert;

endmodule

//--- verilog/pulse_regs.sv
// A control write rewrites all config bits, so clearing status must write back the config
`timescale 1ns/100ps

module pulse_regs (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic [pulse_pkg::addr_w-1:0]   address,
    input  logic [pulse_pkg::data_w-1:0]   data_in,
    input  logic [1:0]                     data_write_n,
    pulse_cfg_if.regs                      cfg,
    output logic [pulse_pkg::data_w-1:0]   data_out,
    output logic                           user_interrupt
);
    import pulse_pkg::*;

    prog_word_u         prog_mem [num_prog_words];
    logic               wr_en;
    logic               run_d;
    logic [num_irq-1:0] int_status;
    logic [num_irq-1:0] int_en;
    logic [num_irq-1:0] irq_evt;

    // Full word writes on a word boundary only
    assign wr_en = (data_write_n == wr_word_code) && (address[1:0] == 2'b00);

    // Enabled events in status field order
    assign irq_evt = {cfg.end_evt, cfg.loop_evt, cfg.symbol_evt} & int_en;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cfg.running      <= 1'b0;
            int_status       <= '0;
            int_en           <= '0;
            cfg.loop_forever <= 1'b0;
            cfg.idle_level   <= 1'b0;
            cfg.invert       <= 1'b0;
            cfg.carrier_en   <= 1'b0;
            cfg.use_2bps     <= 1'b0;
            cfg.sym_code     <= '0;
            cfg.start_idx    <= '0;
            cfg.end_idx      <= '0;
            cfg.loop_idx     <= '0;
            cfg.loop_count   <= '0;
            cfg.dur          <= '0;
            cfg.prescaler    <= '0;
            cfg.carrier_half <= '0;
        end else begin
            int_status <= int_status | irq_evt;
            // Program end drops the run bit at the last symbol edge
            if (cfg.end_evt) begin
                cfg.running <= 1'b0;
            end
            if (wr_en) begin
                case (address)
                    reg_ctrl_addr: begin
                        // Write one to clear while new events still land
                        int_status <= (int_status & ~data_in[ctrl_int_pos +: num_irq]) | irq_evt;
                        // Stop wins over start
                        if (data_in[ctrl_stop_pos]) begin
                            cfg.running <= 1'b0;
                        end else if (data_in[ctrl_start_pos]) begin
                            cfg.running <= 1'b1;
                        end
                        int_en           <= data_in[ctrl_int_en_pos +: num_irq];
                        cfg.loop_forever <= data_in[ctrl_forever_pos];
                        cfg.idle_level   <= data_in[ctrl_idle_pos];
                        cfg.invert       <= data_in[ctrl_invert_pos];
                        cfg.carrier_en   <= data_in[ctrl_carrier_pos];
                        cfg.use_2bps     <= data_in[ctrl_2bps_pos];
                        cfg.sym_code     <= data_in[ctrl_sym_pos +: 8];
                    end
                    reg_index_addr: begin
                        cfg.start_idx  <= data_in[idx_start_pos +: pc_w];
                        cfg.end_idx    <= data_in[idx_end_pos +: pc_w];
                        cfg.loop_idx   <= data_in[idx_loop_pos +: pc_w];
                        cfg.loop_count <= data_in[idx_count_pos +: loop_w];
                    end
                    reg_dur_addr:     cfg.dur          <= data_in;
                    reg_presc_addr:   cfg.prescaler    <= data_in[presc_pos +: presc_w];
                    reg_carrier_addr: cfg.carrier_half <= data_in[carrier_pos +: carrier_w];
                    default: begin
                    end
                endcase
            end
        end
    end

    // Program memory in the upper half of the address space
    always_ff @(posedge clk) begin
        if (wr_en && (address >= prog_base_addr)) begin
            prog_mem[address[prog_idx_w+1:2]] <= data_in;
        end
    end

    assign cfg.prog_word = prog_mem[cfg.word_sel];

    // One-cycle start pulse on the rising run bit
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            run_d <= 1'b0;
        end else begin
            run_d <= cfg.running;
        end
    end

    assign cfg.start_pulse = cfg.running && !run_d;
    assign user_interrupt  = |int_status;

    // Read word ignores the address
    always_comb begin
        data_out = '0;
        data_out[ctrl_int_pos +: num_irq] = int_status;
        data_out[rd_run_pos]              = cfg.running;
        data_out[rd_loop_pos +: loop_w]   = cfg.loop_cnt;
        data_out[rd_pc_pos +: pc_w]       = cfg.pc;
    end

    // A start pulse only follows a start write that stop did not override
    a_start_single: assert property (@(posedge clk) disable iff (!rst_n)
        cfg.start_pulse |-> $past(wr_en && (address == reg_ctrl_addr)
                                  && data_in[ctrl_start_pos] && !data_in[ctrl_stop_pos])
                            ##1 !cfg.start_pulse)
        else $error("start_pulse without a single start write");

endmodule

//--- verilog/pulse_tx_top.sv
// Only 32-bit aligned writes are accepted; data_out is zero unless a read is requested
`timescale 1ns/100ps

module pulse_tx_top (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic [pulse_pkg::addr_w-1:0]   address,
    input  logic [pulse_pkg::data_w-1:0]   data_in,
    input  logic [1:0]                     data_write_n,
    input  logic [1:0]                     data_read_n,
    output logic [pulse_pkg::data_w-1:0]   data_out,
    output logic                           data_ready,
    output logic                           tx_out,
    output logic                           tx_valid,
    output logic                           carrier_out,
    output logic                           user_interrupt
);
    import pulse_pkg::*;

    logic [data_w-1:0] rd_word;
    logic              tx_level;

    pulse_cfg_if cfg ();

    pulse_regs i_pulse_regs (
        .clk            (clk),
        .rst_n          (rst_n),
        .address        (address),
        .data_in        (data_in),
        .data_write_n   (data_write_n),
        .cfg            (cfg),
        .data_out       (rd_word),
        .user_interrupt (user_interrupt)
    );

    pulse_sequencer i_pulse_sequencer (
        .clk      (clk),
        .rst_n    (rst_n),
        .cfg      (cfg),
        .tx_level (tx_level),
        .tx_valid (tx_valid)
    );

    carrier_gen i_carrier_gen (
        .clk         (clk),
        .rst_n       (rst_n),
        .cfg         (cfg),
        .tx_level    (tx_level),
        .tx_valid    (tx_valid),
        .carrier_out (carrier_out),
        .tx_out      (tx_out)
    );

    // Read word is combinational, 2'b11 means no read in flight
    assign data_out = (data_read_n == 2'b11) ? '0 : rd_word;
    // Every access completes in one cycle
    assign data_ready = 1'b1;

endmodule
